// File: compile.f
verilog/cam_cfg_pkg.sv
verilog/i2c_master.sv
verilog/cfg_sequencer.sv
verilog/cam_cfg_top.sv
dv/i2c_sensor_model.sv
dv/tb_cam_cfg.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = tb_cam_cfg
FILELIST  = compile.f
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_cam_cfg.sv
module tb_cam_cfg;

   typedef enum {EV_START, EV_PTR, EV_READ, EV_WRITE, EV_ID_OK, EV_RELEASE} event_t;

   logic                    CLK_400K;
   logic                    RESET_N;
   logic                    sda_in;
   logic                    scl_oe;
   logic                    sda_oe;
   logic [7:0]              sensor_id;
   logic                    id_ok;
   logic                    cam_release;
   logic                    ack_en;
   logic [7:0]              id_byte;
   logic                    start_seen;
   logic                    ptr_seen;
   logic                    read_seen;
   logic                    write_seen;
   cam_cfg_pkg::cfg_entry_t write_entry;
   logic [31:0]             lfsr;
   int                      mismatch_count = 0;
   int                      timeout_count = 0;
   int                      cycle = 0;
   int                      last_start_cyc = 0;

   cam_cfg_top DUT (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .sda_in      (sda_in),
      .scl_oe      (scl_oe),
      .sda_oe      (sda_oe),
      .sensor_id   (sensor_id),
      .id_ok       (id_ok),
      .cam_release (cam_release)
   );

   i2c_sensor_model u_sensor (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .scl_oe      (scl_oe),
      .sda_oe      (sda_oe),
      .ack_en      (ack_en),
      .id_byte     (id_byte),
      .sda_in      (sda_in),
      .start_seen  (start_seen),
      .ptr_seen    (ptr_seen),
      .read_seen   (read_seen),
      .write_seen  (write_seen),
      .write_entry (write_entry)
   );

   initial begin
      CLK_400K = 1'b0;
      forever #50 CLK_400K = ~CLK_400K;
   end

   always @(posedge CLK_400K) begin
      cycle <= cycle + 1;
      if (start_seen) begin
         last_start_cyc <= cycle;
      end
   end

   // a register write on the bus is only legal once the ID has matched
   always @(negedge CLK_400K) begin
      if (write_seen) begin
         check_flag(id_ok, 1'b1, "id_ok at a register write");
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
   endfunction

   task automatic draw_bits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[6:0], lfsr[0]};
      end
   endtask

   task automatic check_entry(input cam_cfg_pkg::cfg_entry_t got,
                              input cam_cfg_pkg::cfg_entry_t exp_val, input string what);
      if (got !== exp_val) begin
         mismatch_count++;
         $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp_val);
      end
   endtask

   task automatic check_id(input logic [7:0] got, input logic [7:0] exp_val, input string what);
      if (got !== exp_val) begin
         mismatch_count++;
         $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp_val);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp_val, input string what);
      if (got !== exp_val) begin
         mismatch_count++;
         $display("Fail at %0t: %s, got %b, expected %b", $time, what, got, exp_val);
      end
   endtask

   task automatic end_run();
      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      timeout_count++;
      $display("Timeout: the %s did not show up within 2000 clocks", what);
      end_run();
   endtask

   // polls on the falling edge, where all outputs have settled
   task automatic wait_for(input event_t sel, input string what);
      int   n;
      logic hit;
      n   = 0;
      hit = 1'b0;
      while (!hit) begin
         @(negedge CLK_400K);
         case (sel)
            EV_START: hit = start_seen;
            EV_PTR:   hit = ptr_seen;
            EV_READ:  hit = read_seen;
            EV_WRITE: hit = write_seen;
            EV_ID_OK: hit = id_ok;
            default:  hit = cam_release;
         endcase
         n++;
         if (!hit && n >= 2000) begin
            report_timeout(what);
         end
      end
   endtask

   initial begin
      logic [7:0]              n_fail;
      logic [7:0]              mode;
      logic [7:0]              exp_id;
      logic                    ack_v;
      cam_cfg_pkg::cfg_entry_t exp_entry;
      int                      min_gap;
      int                      prev_stop;
      int                      gap;
      RESET_N = 1'b0;
      ack_en  = 1'b1;
      id_byte = cam_cfg_pkg::SENSOR_ID;
      lfsr    = 32'h97ed;
      repeat (4) @(posedge CLK_400K);
      RESET_N <= 1'b1;

      for (int i = 0; i < int'(cam_cfg_pkg::POWERUP_WAIT); i++) begin
         @(negedge CLK_400K);
         check_flag(cam_release, 1'b0, "cam_release during power-up");
         check_flag(id_ok, 1'b0, "id_ok during power-up");
         check_flag(scl_oe, 1'b0, "scl_oe during power-up");
         check_flag(sda_oe, 1'b0, "sda_oe during power-up");
      end
      check_id(sensor_id, 8'h00, "sensor_id after reset");

      draw_bits(2, n_fail);   // failing ID attempts before the match
      for (int a = 0; a <= int'(n_fail); a++) begin
         ack_v  = 1'b1;
         exp_id = cam_cfg_pkg::SENSOR_ID;
         if (a < int'(n_fail)) begin
            draw_bits(1, mode);
            if (mode[0]) begin
               ack_v  = 1'b0;   // nacked attempt reads back as 0
               exp_id = 8'h00;
            end else begin
               while (exp_id == cam_cfg_pkg::SENSOR_ID) begin
                  draw_bits(8, exp_id);
               end
            end
         end
         @(posedge CLK_400K);
         ack_en  <= ack_v;
         id_byte <= exp_id;
         wait_for(EV_PTR, "ID pointer write");
         exp_entry = '{kind: cam_cfg_pkg::WRITE_ENTRY, slave: cam_cfg_pkg::SENSOR_ADDR,
                       reg_addr: cam_cfg_pkg::ID_REG, data: 8'h00};
         check_entry(write_entry, exp_entry, "ID pointer write");
         wait_for(EV_READ, "ID read");
         if (a < int'(n_fail)) begin
            wait_for(EV_START, "retry after a failed ID attempt");
            check_flag(id_ok, 1'b0, "id_ok after a failed ID attempt");
            check_id(sensor_id, exp_id, "sensor_id after a failed ID attempt");
         end
      end
      wait_for(EV_ID_OK, "id_ok rise");
      check_id(sensor_id, cam_cfg_pkg::SENSOR_ID, "sensor_id after the ID match");

      min_gap   = 0;
      prev_stop = 0;
      for (int i = 0; i < int'(cam_cfg_pkg::CFG_LEN); i++) begin
         exp_entry = cam_cfg_pkg::cfg_table(cam_cfg_pkg::cfg_index_t'(i));
         if (exp_entry.kind == cam_cfg_pkg::DELAY_ENTRY) begin
            min_gap = int'(exp_entry.data) * int'(cam_cfg_pkg::DELAY_UNIT);
         end else begin
            wait_for(EV_WRITE, "table register write");
            check_entry(write_entry, exp_entry, $sformatf("table write %0d", i));
            check_flag(cam_release, 1'b0, "cam_release at a table write");
            if (min_gap > 0) begin
               gap = last_start_cyc - prev_stop;   // STOP before the delay to next START
               check_flag(gap >= min_gap, 1'b1, $sformatf("gap of %0d clocks after delay", gap));
               min_gap = 0;
            end
            prev_stop = cycle;
         end
      end

      wait_for(EV_RELEASE, "cam_release rise");
      for (int i = 0; i < 200; i++) begin
         @(negedge CLK_400K);
         check_flag(cam_release, 1'b1, "cam_release after the table");
         check_flag(scl_oe, 1'b0, "scl_oe after release");
         check_flag(sda_oe, 1'b0, "sda_oe after release");
         check_flag(start_seen, 1'b0, "START on the bus after release");
      end
      end_run();
   end

endmodule

// File: dv/i2c_sensor_model.sv
module i2c_sensor_model (
   input  logic                    CLK_400K,
   input  logic                    RESET_N,
   input  logic                    scl_oe,
   input  logic                    sda_oe,
   input  logic                    ack_en,       // low leaves the address unacknowledged
   input  logic [7:0]              id_byte,      // byte returned by a read
   output logic                    sda_in,
   output logic                    start_seen,
   output logic                    ptr_seen,
   output logic                    read_seen,
   output logic                    write_seen,
   output cam_cfg_pkg::cfg_entry_t write_entry
);

   logic       scl;
   logic       sda;
   logic       scl_q;
   logic       sda_q;
   logic       drive_low;
   logic       in_ack;
   logic       rw;
   logic       addr_ok;
   logic [3:0] bit_idx;
   logic [2:0] byte_cnt;
   logic [7:0] shift;
   logic [7:0] addr_byte;
   logic [7:0] reg_hi;
   logic [7:0] reg_lo;
   logic [7:0] data_byte;

   assign scl    = !scl_oe;
   assign sda    = !sda_oe && !drive_low;   // open-drain wired and
   assign sda_in = sda;

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         scl_q      <= 1'b1;
         sda_q      <= 1'b1;
         drive_low  <= 1'b0;
         in_ack     <= 1'b0;
         rw         <= 1'b0;
         addr_ok    <= 1'b0;
         bit_idx    <= '0;
         byte_cnt   <= '0;
         start_seen <= 1'b0;
         ptr_seen   <= 1'b0;
         read_seen  <= 1'b0;
         write_seen <= 1'b0;
      end else begin
         scl_q      <= scl;
         sda_q      <= sda;
         start_seen <= 1'b0;
         ptr_seen   <= 1'b0;
         read_seen  <= 1'b0;
         write_seen <= 1'b0;
         if (scl && scl_q && sda_q && !sda) begin           // START
            start_seen <= 1'b1;
            in_ack     <= 1'b0;
            rw         <= 1'b0;
            addr_ok    <= 1'b0;
            bit_idx    <= '0;
            byte_cnt   <= '0;
         end else if (scl && scl_q && !sda_q && sda) begin  // STOP
            read_seen   <= rw;
            ptr_seen    <= !rw && byte_cnt == 3'd3;
            write_seen  <= !rw && byte_cnt == 3'd4;
            write_entry <= '{kind: cam_cfg_pkg::WRITE_ENTRY, slave: addr_byte,
                             reg_addr: {reg_hi, reg_lo},
                             data: (byte_cnt == 3'd4) ? data_byte : 8'h00};
         end else if (scl && !scl_q) begin                  // take a bit on scl rising
            if (!in_ack) begin
               shift   <= {shift[6:0], sda};
               bit_idx <= bit_idx + 4'd1;
            end
         end else if (!scl && scl_q) begin                  // scl falling
            if (in_ack) begin
               in_ack    <= 1'b0;
               bit_idx   <= '0;
               byte_cnt  <= byte_cnt + 3'd1;
               drive_low <= rw && addr_ok && byte_cnt == 3'd0 && !id_byte[7];  // first read bit
            end else if (bit_idx == 4'd8) begin
               in_ack <= 1'b1;
               if (byte_cnt == 3'd0) begin
                  addr_byte <= shift;
                  rw        <= shift[0];
                  addr_ok   <= ack_en && shift[7:1] == cam_cfg_pkg::SENSOR_ADDR[7:1];
                  drive_low <= ack_en && shift[7:1] == cam_cfg_pkg::SENSOR_ADDR[7:1];
               end else if (!rw) begin
                  case (byte_cnt)
                     3'd1:    reg_hi    <= shift;
                     3'd2:    reg_lo    <= shift;
                     default: data_byte <= shift;
                  endcase
                  drive_low <= addr_ok;
               end else begin
                  drive_low <= 1'b0;   // master owns the ack of a read byte
               end
            end else begin
               drive_low <= rw && addr_ok && byte_cnt == 3'd1 &&
                            !id_byte[3'd7 - bit_idx[2:0]];
            end
         end
      end
   end

endmodule

// File: verilog/cam_cfg_top.sv
module cam_cfg_top (
   input  logic       CLK_400K,
   input  logic       RESET_N,
   input  logic       sda_in,
   output logic       scl_oe,
   output logic       sda_oe,
   output logic [7:0] sensor_id,
   output logic       id_ok,
   output logic       cam_release
);

   logic                  start;
   logic                  busy;
   logic                  done;
   cam_cfg_pkg::i2c_cmd_t cmd;
   cam_cfg_pkg::i2c_rsp_t rsp;

   cfg_sequencer u_seq (
      .CLK_400K    (CLK_400K),
      .RESET_N     (RESET_N),
      .busy        (busy),
      .done        (done),
      .rsp         (rsp),
      .start       (start),
      .cmd         (cmd),
      .sensor_id   (sensor_id),
      .id_ok       (id_ok),
      .cam_release (cam_release)
   );

   i2c_master u_i2c (
      .CLK_400K (CLK_400K),
      .RESET_N  (RESET_N),
      .start    (start),
      .cmd      (cmd),
      .sda_in   (sda_in),         // wired-and level from the pad
      .busy     (busy),
      .done     (done),
      .rsp      (rsp),
      .scl_oe   (scl_oe),
      .sda_oe   (sda_oe)
   );

endmodule

// File: verilog/cfg_sequencer.sv
module cfg_sequencer (
   input  logic                  CLK_400K,
   input  logic                  RESET_N,
   input  logic                  busy,
   input  logic                  done,
   input  cam_cfg_pkg::i2c_rsp_t rsp,
   output logic                  start,
   output cam_cfg_pkg::i2c_cmd_t cmd,
   output logic [7:0]            sensor_id,
   output logic                  id_ok,
   output logic                  cam_release
);

   typedef enum logic [3:0] {
      S_POWERUP,
      S_ID_PTR,
      S_ID_PTR_WAIT,
      S_ID_READ,
      S_ID_READ_WAIT,
      S_RETRY,
      S_FETCH,
      S_WRITE_WAIT,
      S_DELAY,
      S_RELEASE
   } state_t;

   state_t                    state;
   logic [15:0]               wait_cnt;
   logic                      ptr_nack;     // pointer write of this attempt failed
   cam_cfg_pkg::cfg_index_t   idx;
   cam_cfg_pkg::cfg_entry_t   entry;
   logic [15:0]               dly_len;
   logic                      last_entry;

   assign entry      = cam_cfg_pkg::cfg_table(idx);
   assign dly_len    = {8'h00, entry.data} * {8'h00, cam_cfg_pkg::DELAY_UNIT};
   assign last_entry = (idx == cam_cfg_pkg::CFG_LEN - 8'd1);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state       <= S_POWERUP;
         wait_cnt    <= '0;
         ptr_nack    <= 1'b0;
         idx         <= '0;
         start       <= 1'b0;
         sensor_id   <= 8'h00;
         id_ok       <= 1'b0;
         cam_release <= 1'b0;
      end else begin
         start <= 1'b0;
         case (state)
            S_POWERUP: begin
               wait_cnt <= wait_cnt + 16'd1;
               if (wait_cnt == cam_cfg_pkg::POWERUP_WAIT - 16'd1) begin
                  state <= S_ID_PTR;
               end
            end
            S_ID_PTR: begin
               if (!busy) begin
                  start <= 1'b1;
                  cmd   <= '{op: cam_cfg_pkg::OP_WRITE_PTR, slave: cam_cfg_pkg::SENSOR_ADDR,
                             reg_addr: cam_cfg_pkg::ID_REG, data: 8'h00};
                  state <= S_ID_PTR_WAIT;
               end
            end
            S_ID_PTR_WAIT: begin
               if (done) begin
                  ptr_nack <= rsp.nack;
                  state    <= S_ID_READ;
               end
            end
            S_ID_READ: begin
               if (!busy) begin
                  start <= 1'b1;
                  cmd   <= '{op: cam_cfg_pkg::OP_READ_BYTE, slave: cam_cfg_pkg::SENSOR_ADDR,
                             reg_addr: cam_cfg_pkg::ID_REG, data: 8'h00};
                  state <= S_ID_READ_WAIT;
               end
            end
            S_ID_READ_WAIT: begin
               if (done) begin
                  sensor_id <= rsp.nack ? 8'h00 : rsp.rd_data;
                  wait_cnt  <= '0;
                  if (ptr_nack || rsp.nack || rsp.rd_data != cam_cfg_pkg::SENSOR_ID) begin
                     state <= S_RETRY;
                  end else begin
                     id_ok <= 1'b1;
                     idx   <= '0;
                     state <= S_FETCH;
                  end
               end
            end
            S_RETRY: begin
               wait_cnt <= wait_cnt + 16'd1;
               if (wait_cnt == cam_cfg_pkg::RETRY_WAIT - 16'd1) begin
                  state <= S_ID_PTR;
               end
            end
            S_FETCH: begin
               if (entry.kind == cam_cfg_pkg::DELAY_ENTRY) begin
                  wait_cnt <= '0;
                  state    <= S_DELAY;
               end else if (!busy) begin
                  start <= 1'b1;
                  cmd   <= '{op: cam_cfg_pkg::OP_WRITE_REG, slave: entry.slave,
                             reg_addr: entry.reg_addr, data: entry.data};
                  state <= S_WRITE_WAIT;
               end
            end
            S_WRITE_WAIT, S_DELAY: begin
               if (state == S_DELAY && wait_cnt < dly_len) begin
                  wait_cnt <= wait_cnt + 16'd1;
               end else if (state == S_DELAY || done) begin   // write nack ignored
                  if (last_entry) begin
                     cam_release <= 1'b1;
                     state       <= S_RELEASE;
                  end else begin
                     idx   <= idx + 8'd1;
                     state <= S_FETCH;
                  end
               end
            end
            S_RELEASE: state <= S_RELEASE;   // done for good
            default:   state <= S_POWERUP;
         endcase
      end
   end

endmodule

// File: verilog/i2c_master.sv
module i2c_master (
   input  logic                  CLK_400K,
   input  logic                  RESET_N,
   input  logic                  start,
   input  cam_cfg_pkg::i2c_cmd_t cmd,
   input  logic                  sda_in,
   output logic                  busy,
   output logic                  done,
   output cam_cfg_pkg::i2c_rsp_t rsp,
   output logic                  scl_oe,
   output logic                  sda_oe
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_BIT,
      S_STOP
   } state_t;

   state_t                          state;
   logic [cam_cfg_pkg::PHASE_W-1:0] phase;
   logic [3:0]                      bit_cnt;    // data bits 0..7 then ack slot 8
   logic [1:0]                      byte_idx;
   logic [1:0]                      last_byte;
   cam_cfg_pkg::i2c_cmd_t           cmd_r;
   logic [7:0]                      tx_byte;
   logic                            rx_byte;    // target drives this byte
   logic                            sda_drv;
   logic [7:0]                      rx_shift;
   logic                            nack_r;
   logic                            bit_end;

   assign bit_end = (phase == cam_cfg_pkg::PHASE_LAST);
   assign rx_byte = (cmd_r.op == cam_cfg_pkg::OP_READ_BYTE) && (byte_idx == 2'd1);

   always_comb begin
      case (cmd_r.op)
         cam_cfg_pkg::OP_READ_BYTE: last_byte = 2'd1;
         cam_cfg_pkg::OP_WRITE_PTR: last_byte = 2'd2;
         default:                   last_byte = 2'd3;
      endcase
   end

   always_comb begin
      case (byte_idx)
         2'd0:    tx_byte = {cmd_r.slave[7:1], cmd_r.op == cam_cfg_pkg::OP_READ_BYTE};
         2'd1:    tx_byte = cmd_r.reg_addr[15:8];
         2'd2:    tx_byte = cmd_r.reg_addr[7:0];
         default: tx_byte = cmd_r.data;
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state    <= S_IDLE;
         phase    <= '0;
         bit_cnt  <= '0;
         byte_idx <= '0;
         sda_drv  <= 1'b0;
         done     <= 1'b0;
      end else begin
         done <= 1'b0;
         if (state != S_IDLE) begin
            phase <= bit_end ? '0 : phase + 1'b1;
         end
         case (state)
            S_IDLE: begin
               if (start) begin                  // start while busy never gets here
                  state    <= S_START;
                  bit_cnt  <= '0;
                  byte_idx <= '0;
               end
            end
            S_START: begin
               if (phase == '0) begin
                  sda_drv <= 1'b1;               // sda falls while scl is high
               end
               if (bit_end) begin
                  state <= S_BIT;
               end
            end
            S_BIT: begin
               if (phase == '0) begin            // scl is low so sda may change
                  sda_drv <= (bit_cnt < 4'd8) && !rx_byte && !tx_byte[~bit_cnt[2:0]];
               end
               if (bit_end) begin
                  if (bit_cnt == 4'd8) begin
                     bit_cnt <= '0;
                     if (byte_idx == last_byte) begin
                        state <= S_STOP;
                     end else begin
                        byte_idx <= byte_idx + 2'd1;
                     end
                  end else begin
                     bit_cnt <= bit_cnt + 4'd1;
                  end
               end
            end
            S_STOP: begin
               if (phase == '0) begin
                  sda_drv <= 1'b1;
               end else if (phase == cam_cfg_pkg::PHASE_LAST - 1'b1) begin
                  sda_drv <= 1'b0;               // sda rises with scl high
               end
               if (bit_end) begin
                  state <= S_IDLE;
                  done  <= 1'b1;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // command and response payload
   always_ff @(posedge CLK_400K) begin
      if (state == S_IDLE && start) begin
         cmd_r  <= cmd;
         nack_r <= 1'b0;
      end
      if (state == S_BIT && bit_end) begin     // sample at end of scl high
         if (bit_cnt < 4'd8 && rx_byte) begin
            rx_shift <= {rx_shift[6:0], sda_in};
         end
         if (bit_cnt == 4'd8 && !rx_byte && sda_in) begin
            nack_r <= 1'b1;                     // target left sda high
         end
      end
   end

   assign busy   = (state != S_IDLE);
   assign scl_oe = (state == S_BIT || state == S_STOP) && (phase < cam_cfg_pkg::PHASE_HIGH);
   assign sda_oe = sda_drv;
   assign rsp    = '{rd_data: rx_shift, nack: nack_r};

endmodule

// File: verilog/cam_cfg_pkg.sv
package cam_cfg_pkg;

   localparam logic [7:0]  SENSOR_ADDR  = 8'h6c;      // write form of 7-bit address 36h
   localparam logic [15:0] ID_REG       = 16'h300b;
   localparam logic [7:0]  SENSOR_ID    = 8'h88;
   localparam logic [15:0] POWERUP_WAIT = 16'd400;    // about 1 ms at 400 kHz
   localparam logic [15:0] RETRY_WAIT   = 16'd100;
   localparam logic [7:0]  DELAY_UNIT   = 8'd16;
   localparam logic [7:0]  CFG_LEN      = 8'd20;

   // 4 clocks per bit gives 100 kHz SCL
   localparam int PHASES_PER_BIT = 4;
   localparam int PHASE_W        = $clog2(PHASES_PER_BIT);
   localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(PHASES_PER_BIT - 1);
   localparam logic [PHASE_W-1:0] PHASE_HIGH = PHASE_W'(PHASES_PER_BIT / 2);  // first scl high

   typedef enum logic {
      WRITE_ENTRY,
      DELAY_ENTRY
   } entry_kind_t;

   typedef struct packed {
      entry_kind_t kind;
      logic [7:0]  slave;
      logic [15:0] reg_addr;
      logic [7:0]  data;       // delay length in DELAY_UNIT steps for delay entries
   } cfg_entry_t;

   typedef enum logic [1:0] {
      OP_WRITE_PTR,
      OP_READ_BYTE,
      OP_WRITE_REG
   } i2c_op_t;

   typedef struct packed {
      i2c_op_t     op;
      logic [7:0]  slave;
      logic [15:0] reg_addr;
      logic [7:0]  data;
   } i2c_cmd_t;

   typedef struct packed {
      logic [7:0] rd_data;
      logic       nack;
   } i2c_rsp_t;

   typedef logic [7:0] cfg_index_t;

   function automatic cfg_entry_t wr(input logic [15:0] r, input logic [7:0] d);
      return '{kind: WRITE_ENTRY, slave: SENSOR_ADDR, reg_addr: r, data: d};
   endfunction

   function automatic cfg_entry_t dly(input logic [7:0] units);
      return '{kind: DELAY_ENTRY, slave: 8'h00, reg_addr: 16'h0000, data: units};
   endfunction

   function automatic cfg_entry_t cfg_table(input cfg_index_t idx);
      case (idx)
         8'd0:    return wr(16'h0103, 8'h01);   // software reset
         8'd1:    return wr(16'h0100, 8'h00);   // standby
         8'd2:    return dly(8'd10);
         8'd3:    return wr(16'h3638, 8'hff);   // analog control
         8'd4:    return wr(16'h0302, 8'd24);   // pll1 multiplier
         8'd5:    return wr(16'h0303, 8'h00);
         8'd6:    return wr(16'h0304, 8'h03);   // pll1 mipi divider
         8'd7:    return wr(16'h030e, 8'h00);
         8'd8:    return wr(16'h0312, 8'h01);
         8'd9:    return wr(16'h3018, 8'h72);   // mipi 4 lane
         8'd10:   return wr(16'h3808, 8'h02);   // x size 640
         8'd11:   return wr(16'h3809, 8'h80);
         8'd12:   return wr(16'h380a, 8'h01);   // y size 480
         8'd13:   return wr(16'h380b, 8'he0);
         8'd14:   return wr(16'h3508, 8'h03);   // analog gain
         8'd15:   return wr(16'h3509, 8'h00);
         8'd16:   return wr(16'h5018, 8'h19);   // red wb gain
         8'd17:   return dly(8'd10);
         8'd18:   return wr(16'h501c, 8'h17);   // blue wb gain
         8'd19:   return wr(16'h0100, 8'h01);   // wake up, streaming
         default: return dly(8'd0);
      endcase
   endfunction

endpackage
